// File: list.f
hdl/aesPkg.sv
hdl/aesRoundCore.sv
hdl/keystreamLane.sv
hdl/laneScheduler.sv
hdl/aesKeystreamTop.sv
dv/aesKeystream_assert.sv
dv/aesKeystreamTb.sv

// File: dv/aesKeystreamTb.sv
// ----------------------------------------------------------------------
// Keystream generator testbench: random stimulus, AES model,
// in-order scoreboard with latency check, timeouts
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module aesKeystreamTb;
    import aesPkg::*;

    localparam int laneCount    = 12;
    localparam int coresPerLane = 2;
    localparam int wordW        = coresPerLane * 128;
    localparam int waitLimit    = 40;

    logic             Clock;
    logic             rstN;
    logic             reqValid;
    logic             reqReady;
    aesReqT           req;
    logic             keyOutValid;
    logic [wordW-1:0] keyOut;

    // Scoreboard state
    logic [wordW-1:0] expQ [$];
    int               edgeQ [$];
    int               edgeCount;
    int               outCount;
    logic [wordW-1:0] lastKeyOut;
    aesReqT           stimReq;

    aesKeystreamTop #(
        .laneCount    (laneCount),
        .coresPerLane (coresPerLane)
    ) UUT (
        .Clock       (Clock),
        .rstN        (rstN),
        .reqValid    (reqValid),
        .reqReady    (reqReady),
        .req         (req),
        .keyOutValid (keyOutValid),
        .keyOut      (keyOut)
    );

    initial Clock = 1'b0;
    always #20 Clock = ~Clock;

    always @(posedge Clock) edgeCount++;

    // ------------------------------------------------------------------
    // Failure reporting and the compare task
    // ------------------------------------------------------------------
    task automatic failRun(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [wordW-1:0] expected,
                              input logic [wordW-1:0] actual);
        if (expected !== actual) begin
            $display("** Error %s expected %h actual %h", name, expected, actual);
            failRun("value mismatch");
        end
    endtask

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------
    // Plain FIPS-197 cipher loop
    function automatic blockT encryptBlock(blockT pt, keyT key);
        blockT s;
        keyT   k;
        int    b;
        s = pt ^ key;
        k = key;
        for (int r = 1; r <= 10; r++) begin
            k = nextRoundKey(k, roundT'(r));
            for (b = 0; b < 16; b++) begin
                s[b * 8 +: 8] = subByte(s[b * 8 +: 8]);
            end
            s = shiftRows(s);
            if (r < 10) begin
                s = mixColumns(s);
            end
            s = s ^ k;
        end
        return s;
    endfunction

    // Block j of the word is counter+j, wrapping at 2^128
    function automatic logic [wordW-1:0] expectedWord(aesReqT r);
        logic [wordW-1:0] w;
        for (int j = 0; j < coresPerLane; j++) begin
            w[j * 128 +: 128] = encryptBlock(r.counter + blockT'(j), r.key);
        end
        return w;
    endfunction

    function automatic aesReqT randomReq(input bit nearTop);
        aesReqT r;
        r.counter = {$urandom, $urandom, $urandom, $urandom};
        r.key     = {$urandom, $urandom, $urandom, $urandom};
        // Counters just below all ones force the carry wrap
        if (nearTop && $urandom_range(3) == 0) begin
            r.counter = '1 - blockT'($urandom_range(2));
        end
        return r;
    endfunction

    // ------------------------------------------------------------------
    // Monitor, sampled mid-cycle where outputs are settled
    // ------------------------------------------------------------------
    always @(negedge Clock) begin
        if (rstN) begin
            if (keyOutValid) begin
                if (expQ.size() == 0) begin
                    failRun("keyOutValid seen with no request in flight");
                end else begin
                    checkValue("keyOut", expQ.pop_front(), keyOut);
                    // Accepted at edge N, strobe follows edge N+10
                    checkValue("keyOutValid latency", 10, edgeCount - edgeQ.pop_front());
                    lastKeyOut = keyOut;
                    outCount++;
                end
            end
            if (reqValid && reqReady) begin
                expQ.push_back(expectedWord(req));
                edgeQ.push_back(edgeCount + 1);
            end
        end
    end

    // ------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------
    // Called 1 ns after a rising edge, returns at the same point
    task automatic driveRequest(input aesReqT r, input bit mustBeReady);
        int n;
        n        = 0;
        reqValid = 1'b1;
        req      = r;
        @(negedge Clock);
        if (mustBeReady) begin
            checkValue("reqReady", 1, reqReady);
        end
        while (!reqReady) begin
            n++;
            if (n > waitLimit) begin
                failRun("timed out waiting for reqReady");
            end
            @(negedge Clock);
        end
        @(posedge Clock);
        #1;
    endtask

    task automatic waitOutputs(input int target);
        int n;
        n = 0;
        while (outCount < target || expQ.size() != 0) begin
            @(posedge Clock);
            n++;
            if (n > waitLimit) begin
                failRun("timed out waiting for keystream results");
            end
        end
        #1;
    endtask

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin
        void'($urandom(51200));
        rstN      = 1'b0;
        reqValid  = 1'b0;
        req       = '0;
        edgeCount = 0;
        outCount  = 0;
        repeat (2) @(posedge Clock);
        #1;
        rstN = 1'b1;

        // Idle after reset
        repeat (3) begin
            @(negedge Clock);
            checkValue("reqReady", 1, reqReady);
            checkValue("keyOutValid", 0, keyOutValid);
        end
        @(posedge Clock);
        #1;

        // Known answer, FIPS-197 appendix C.1 in block 0
        stimReq.key     = 128'h000102030405060708090a0b0c0d0e0f;
        stimReq.counter = 128'h00112233445566778899aabbccddeeff;
        driveRequest(stimReq, 1'b1);
        reqValid = 1'b0;
        waitOutputs(1);
        checkValue("keyOut[127:0]", 128'h69c4e0d86a7b0430d8cdb78070b4c55a,
                   lastKeyOut[127:0]);
        // Single strobe per request
        repeat (3) @(posedge Clock);
        #1;
        checkValue("keyOutValid count", 1, outCount);

        // Back-to-back stream at full rate
        for (int i = 0; i < 200; i++) begin
            driveRequest(randomReq(1'b0), 1'b1);
        end
        reqValid = 1'b0;
        waitOutputs(201);

        // Random gaps and wrapping counters
        for (int i = 0; i < 150; i++) begin
            if ($urandom_range(2) == 0) begin
                reqValid = 1'b0;
                req      = randomReq(1'b1);
                @(posedge Clock);
                #1;
            end else begin
                driveRequest(randomReq(1'b1), 1'b0);
            end
        end
        reqValid = 1'b0;
        waitOutputs(outCount);

        repeat (5) @(posedge Clock);
        if (expQ.size() != 0 || edgeQ.size() != 0) begin
            failRun("results missing at end of run");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

// File: dv/aesKeystream_assert.sv
// ----------------------------------------------------------------------
// Scheduler assertions: load to idle lane, output from busy lane,
// fixed load to done latency per lane
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module aesKeystreamAssert #(
    parameter int laneCount = 12,
    parameter int idxW      = (laneCount > 1) ? $clog2(laneCount) : 1
) (
    input logic                 Clock,
    input logic                 rstN,
    input logic [laneCount-1:0] laneLoad,
    input logic [laneCount-1:0] laneDone,
    input logic [laneCount-1:0] busy,
    input logic [idxW-1:0]      outTurn,
    input logic                 keyOutValid
);
    import aesPkg::*;

    // Output only from the lane whose turn it is, while busy
    validFromBusy: assert property (@(posedge Clock) disable iff (!rstN)
        keyOutValid |-> busy[outTurn])
        else $error("keyOutValid while lane outTurn is idle");

    genvar i;
    generate
        for (i = 0; i < laneCount; i++) begin : genLaneChk
            // No load into a lane still working, busy until the edge after done
            noReload: assert property (@(posedge Clock) disable iff (!rstN)
                laneLoad[i] |=> (!laneLoad[i]) [*roundLatency])
                else $error("load issued to a busy lane");

            // Done exactly roundLatency cycles after load
            loadToDone: assert property (@(posedge Clock) disable iff (!rstN)
                laneLoad[i] |-> ##roundLatency laneDone[i])
                else $error("lane done missing after load");
        end
    endgenerate

endmodule

bind laneScheduler aesKeystreamAssert #(
    .laneCount (laneCount)
) schedAssert (
    .Clock       (Clock),
    .rstN        (rstN),
    .laneLoad    (laneLoad),
    .laneDone    (laneDone),
    .busy        (busy),
    .outTurn     (outTurn),
    .keyOutValid (keyOutValid)
);

// File: hdl/aesKeystreamTop.sv
// ----------------------------------------------------------------------
// Keystream generator top, scheduler and laneCount lanes
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module aesKeystreamTop #(
    parameter int laneCount    = 12,
    parameter int coresPerLane = 2
) (
    input  logic                          Clock,
    input  logic                          rstN,
    input  logic                          reqValid,
    output logic                          reqReady,
    input  aesPkg::aesReqT                req,
    output logic                          keyOutValid,
    output logic [coresPerLane*128-1:0]   keyOut
);
    import aesPkg::*;

    // Scheduler to lane wiring
    logic [laneCount-1:0]        laneLoad;
    logic [laneCount-1:0]        laneDone;
    aesReqT                      laneReq;
    logic [coresPerLane*128-1:0] laneResult [laneCount];

    // ------------------------------------------------------------------
    // Dispatch and in-order collection
    // ------------------------------------------------------------------
    laneScheduler #(
        .laneCount    (laneCount),
        .coresPerLane (coresPerLane)
    ) scheduler (
        .Clock       (Clock),
        .rstN        (rstN),
        .reqValid    (reqValid),
        .reqReady    (reqReady),
        .req         (req),
        .laneLoad    (laneLoad),
        .laneReq     (laneReq),
        .laneDone    (laneDone),
        .laneResult  (laneResult),
        .keyOutValid (keyOutValid),
        .keyOut      (keyOut)
    );

    // ------------------------------------------------------------------
    // Lanes
    // ------------------------------------------------------------------
    genvar i;
    generate
        for (i = 0; i < laneCount; i++) begin : genLane
            keystreamLane #(
                .coresPerLane (coresPerLane)
            ) lane (
                .Clock  (Clock),
                .rstN   (rstN),
                .load   (laneLoad[i]),
                .req    (laneReq),
                .done   (laneDone[i]),
                .result (laneResult[i])
            );
        end
    endgenerate

endmodule

// File: hdl/laneScheduler.sv
// ----------------------------------------------------------------------
// Round-robin lane dispatch, busy tracking, in-order output select
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module laneScheduler #(
    parameter int laneCount    = 12,
    parameter int coresPerLane = 2
) (
    input  logic                          Clock,
    input  logic                          rstN,
    input  logic                          reqValid,
    output logic                          reqReady,
    input  aesPkg::aesReqT                req,
    output logic [laneCount-1:0]          laneLoad,
    output aesPkg::aesReqT                laneReq,
    input  logic [laneCount-1:0]          laneDone,
    input  logic [coresPerLane*128-1:0]   laneResult [laneCount],
    output logic                          keyOutValid,
    output logic [coresPerLane*128-1:0]   keyOut
);

    // Lane index width, at least one bit
    localparam int idxW = (laneCount > 1) ? $clog2(laneCount) : 1;

    typedef logic [idxW-1:0] laneIdxT;

    localparam laneIdxT lastLane = laneIdxT'(laneCount - 1);

    laneIdxT              inTurn;
    laneIdxT              outTurn;
    logic [laneCount-1:0] busy;
    logic                 accept;

    // ------------------------------------------------------------------
    // Input side
    // ------------------------------------------------------------------
    assign reqReady = !busy[inTurn];
    assign accept   = reqValid && reqReady;

    // Shared request bus, only the loaded lane samples it
    assign laneReq = req;

    // One-hot load for the lane in turn
    always_comb begin
        laneLoad         = '0;
        laneLoad[inTurn] = accept;
    end

    // ------------------------------------------------------------------
    // Output side
    // ------------------------------------------------------------------
    // Fixed latency keeps completions in acceptance order
    assign keyOutValid = laneDone[outTurn];
    assign keyOut      = laneResult[outTurn];

    // ------------------------------------------------------------------
    // Turn pointers and busy bits
    // ------------------------------------------------------------------
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            inTurn  <= '0;
            outTurn <= '0;
        end else begin
            if (accept) begin
                inTurn <= (inTurn == lastLane) ? '0 : inTurn + laneIdxT'(1);
            end
            if (keyOutValid) begin
                outTurn <= (outTurn == lastLane) ? '0 : outTurn + laneIdxT'(1);
            end
        end
    end

    // Load only hits an idle lane and done only a busy one
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            busy <= '0;
        end else begin
            for (int i = 0; i < laneCount; i++) begin
                if (keyOutValid && outTurn == laneIdxT'(i)) begin
                    busy[i] <= 1'b0;
                end else if (laneLoad[i]) begin
                    busy[i] <= 1'b1;
                end
            end
        end
    end

endmodule

// File: hdl/keystreamLane.sv
// ----------------------------------------------------------------------
// One keystream lane, coresPerLane cores on consecutive counters
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module keystreamLane #(
    parameter int coresPerLane = 2
) (
    input  logic                          Clock,
    input  logic                          rstN,
    input  logic                          load,
    input  aesPkg::aesReqT                req,
    output logic                          done,
    output logic [coresPerLane*128-1:0]   result
);
    import aesPkg::*;

    // Per-core completion
    logic [coresPerLane-1:0] coreDone;

    // ------------------------------------------------------------------
    // Cores, core j encrypts counter+j
    // ------------------------------------------------------------------
    genvar j;
    generate
        for (j = 0; j < coresPerLane; j++) begin : genCore
            blockT coreBlock;

            // Wraps modulo 2^128
            assign coreBlock = req.counter + blockT'(j);

            aesRoundCore core (
                .Clock  (Clock),
                .rstN   (rstN),
                .load   (load),
                .block  (coreBlock),
                .key    (req.key),
                .done   (coreDone[j]),
                .result (result[j*128 +: 128])
            );
        end
    endgenerate

    // All cores start together so their done pulses line up
    assign done = &coreDone;

endmodule

// File: hdl/aesRoundCore.sv
// ----------------------------------------------------------------------
// Iterative AES-128 encryption core, one round per clock,
// round keys expanded on the fly
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module aesRoundCore (
    input  logic          Clock,
    input  logic          rstN,
    input  logic          load,
    input  aesPkg::blockT block,
    input  aesPkg::keyT   key,
    output logic          done,
    output aesPkg::blockT result
);
    import aesPkg::*;

    typedef enum logic {
        idle,
        running
    } coreStateT;

    // Final round skips MixColumns
    localparam roundT lastRound = roundT'(10);

    coreStateT coreState;
    roundT     round;

    // Datapath registers
    blockT aesState;
    keyT   roundKey;

    // Combinational round
    keyT   nextKey;
    blockT subState;
    blockT shifted;
    blockT mixed;

    // ------------------------------------------------------------------
    // One full round on the current state
    // ------------------------------------------------------------------
    always_comb begin
        nextKey  = nextRoundKey(roundKey, round);
        subState = {subWord(aesState[127:96]), subWord(aesState[95:64]),
                    subWord(aesState[63:32]), subWord(aesState[31:0])};
        shifted  = shiftRows(subState);
        mixed    = (round == lastRound) ? shifted : mixColumns(shifted);
    end

    // ------------------------------------------------------------------
    // Control FSM
    // ------------------------------------------------------------------
    // Load at edge N, rounds at edges N+1 .. N+10, so done
    // follows roundLatency cycles after the load
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            coreState <= idle;
            round     <= '0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            case (coreState)
                idle: begin
                    if (load) begin
                        coreState <= running;
                        round     <= roundT'(1);
                    end
                end
                running: begin
                    if (round == lastRound) begin
                        coreState <= idle;
                        done      <= 1'b1;
                    end else begin
                        round <= round + roundT'(1);
                    end
                end
                default: coreState <= idle;
            endcase
        end
    end

    // Initial AddRoundKey on load, then one round per cycle
    always_ff @(posedge Clock) begin
        if (coreState == idle && load) begin
            aesState <= block ^ key;
            roundKey <= key;
        end else if (coreState == running) begin
            aesState <= mixed ^ nextKey;
            roundKey <= nextKey;
        end
    end

    // Ciphertext stays in place while idle
    assign result = aesState;

endmodule

// File: hdl/aesPkg.sv
// ----------------------------------------------------------------------
// Shared AES-128 types, request struct, round constants and the
// round transform functions used by the cores and the model
// ----------------------------------------------------------------------
package aesPkg;

    // Block, key and round counter widths
    typedef logic [127:0] blockT;
    typedef logic [127:0] keyT;
    typedef logic [3:0]   roundT;

    // Request as seen at the top, the scheduler and the lanes
    typedef struct packed {
        blockT counter;
        keyT   key;
    } aesReqT;

    // Load to result of one core, in cycles
    localparam int roundLatency = 11;

    // ------------------------------------------------------------------
    // S-box, one row of 16 bytes per literal, entry 0 first
    // ------------------------------------------------------------------
    localparam logic [0:255][7:0] sBoxTable = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    function automatic logic [7:0] subByte(logic [7:0] b);
        return sBoxTable[b];
    endfunction

    // S-box on each byte of a 32-bit word
    function automatic logic [31:0] subWord(logic [31:0] w);
        return {subByte(w[31:24]), subByte(w[23:16]), subByte(w[15:8]), subByte(w[7:0])};
    endfunction

    // Round constant for key expansion rounds 1 to 10
    function automatic logic [7:0] rcon(roundT r);
        case (r)
            4'd1:    return 8'h01;
            4'd2:    return 8'h02;
            4'd3:    return 8'h04;
            4'd4:    return 8'h08;
            4'd5:    return 8'h10;
            4'd6:    return 8'h20;
            4'd7:    return 8'h40;
            4'd8:    return 8'h80;
            4'd9:    return 8'h1b;
            4'd10:   return 8'h36;
            default: return 8'h00;
        endcase
    endfunction

    // ------------------------------------------------------------------
    // Round transforms, byte 0 of the state sits in bits 127:120
    // ------------------------------------------------------------------

    // Byte in row r, column c moves left by r columns
    function automatic blockT shiftRows(blockT s);
        blockT outState;
        int col;
        int row;
        for (col = 0; col < 4; col++) begin
            for (row = 0; row < 4; row++) begin
                outState[127 - 8 * (4 * col + row) -: 8] =
                    s[127 - 8 * (4 * ((col + row) % 4) + row) -: 8];
            end
        end
        return outState;
    endfunction

    // Multiply by x in GF(2^8)
    function automatic logic [7:0] xtime(logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic blockT mixColumns(blockT s);
        blockT outState;
        logic [7:0] a0;
        logic [7:0] a1;
        logic [7:0] a2;
        logic [7:0] a3;
        int col;
        for (col = 0; col < 4; col++) begin
            a0 = s[127 - 32 * col -: 8];
            a1 = s[119 - 32 * col -: 8];
            a2 = s[111 - 32 * col -: 8];
            a3 = s[103 - 32 * col -: 8];
            // Rows of the fixed matrix 2 3 1 1 and its rotations
            outState[127 - 32 * col -: 8] = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
            outState[119 - 32 * col -: 8] = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
            outState[111 - 32 * col -: 8] = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
            outState[103 - 32 * col -: 8] = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
        end
        return outState;
    endfunction

    // One key expansion step, r is the round being produced
    function automatic keyT nextRoundKey(keyT k, roundT r);
        logic [31:0] temp;
        logic [31:0] w0;
        logic [31:0] w1;
        logic [31:0] w2;
        logic [31:0] w3;
        // RotWord then SubWord on the last word, then the round constant
        temp = subWord({k[23:0], k[31:24]}) ^ {rcon(r), 24'h000000};
        w0 = k[127:96] ^ temp;
        w1 = k[95:64] ^ w0;
        w2 = k[63:32] ^ w1;
        w3 = k[31:0] ^ w2;
        return {w0, w1, w2, w3};
    endfunction

endpackage
